// File: soc_pkg.sv
package soc_pkg;

  ////////////////////////////////////////
  // system sizes and clock
  ////////////////////////////////////////

  localparam int NUM_UARTS = 2;
  localparam logic [31:0] SYSTEM_CLK = 32'd50_000_000;

  localparam int RAM_WORDS = 256;
  localparam logic [31:0] RAM_BYTES = 32'(RAM_WORDS * 4);
  localparam int RAM_AW = $clog2(RAM_WORDS);

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  // inclusive on both ends
  localparam logic [31:0] IO_START = 32'h1000_0000;
  localparam logic [31:0] IO_END = 32'h1200_0000;

  localparam logic [31:0] UART_BASE = 32'h1000_0000;
  localparam logic [31:0] UART_STRIDE = 32'h100;
  localparam logic [7:0] UART_DATA_OFS = 8'h00;
  localparam logic [7:0] UART_LSR_OFS = 8'h04;

  localparam logic [31:0] SYS_BASE = 32'h1100_0000;
  localparam logic [31:0] SYS_SPAN = 32'h100;
  localparam logic [7:0] FREQ_OFS = 8'h00;
  localparam logic [7:0] MEMSIZE_OFS = 8'h04;
  localparam logic [7:0] DIV_OFS = 8'h10;

  // low half is the uart bit period in clocks
  localparam logic [31:0] DIV_RESET = 32'h0010_0008;

  ////////////////////////////////////////
  // uart line status
  ////////////////////////////////////////

  localparam int LSR_DR_BIT = 8;
  localparam int LSR_THRE_BIT = 13;
  localparam int LSR_TEMT_BIT = 14;
  localparam logic [31:0] RX_EMPTY = 32'hFFFF_FFFF;

endpackage

// File: bus_if.sv
`timescale 1ns/1ps

interface bus_if;
  logic        valid;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        ready;
  logic [31:0] rdata;

  // request side, driven by the address decoder
  modport fabric (
    output valid, addr, wdata, wstrb,
    input  ready, rdata
  );

  // one-shot ready, one cycle after valid
  modport target (
    input  valid, addr, wdata, wstrb,
    output ready, rdata
  );
endinterface

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic        clk,
  input  logic        resetn,
  input  logic        start_i,
  input  logic [7:0]  data_i,
  input  logic [15:0] div_i,
  output logic        busy_o,
  output logic        tx_o
);

  logic busy_q, tx_q, bit_end;
  logic [15:0] cnt;
  logic [3:0] bitn;
  // data bits then the stop bit
  logic [8:0] shreg;

  assign bit_end = cnt == (div_i - 16'd1);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy_q <= 1'b0;
      tx_q <= 1'b1;
      cnt <= 16'd0;
      bitn <= 4'd0;
    end else if (!busy_q) begin
      if (start_i) begin
        busy_q <= 1'b1;
        tx_q <= 1'b0;
        cnt <= 16'd0;
        bitn <= 4'd0;
      end
    end else if (bit_end) begin
      cnt <= 16'd0;
      if (bitn == 4'd9) begin
        busy_q <= 1'b0;
        tx_q <= 1'b1;
      end else begin
        tx_q <= shreg[0];
        bitn <= bitn + 4'd1;
      end
    end else begin
      cnt <= cnt + 16'd1;
    end
  end

  // lsb first, ones shifted in behind
  always_ff @(posedge clk) begin
    if (!busy_q && start_i) begin
      shreg <= {1'b1, data_i};
    end else if (busy_q && bit_end) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

  assign busy_o = busy_q;
  assign tx_o = tx_q;

  a_idle_high: assert property (@(posedge clk) disable iff (!resetn) !busy_o |-> tx_o);

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
  input  logic        clk,
  input  logic        resetn,
  input  logic        rx_i,
  input  logic [15:0] div_i,
  output logic        byte_valid_o,
  output logic [7:0]  byte_o
);

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} rx_state_t;

  rx_state_t state;
  logic rx_meta, rx_sync, rx_prev, valid_q;
  logic [15:0] cnt, half_end, bit_end;
  logic [2:0] bitn;
  logic [7:0] shreg;

  // two-flop synchronizer plus edge history
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign half_end = {1'b0, div_i[15:1]} - 16'd1;
  assign bit_end = div_i - 16'd1;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= S_IDLE;
      cnt <= 16'd0;
      bitn <= 3'd0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      cnt <= cnt + 16'd1;
      case (state)
        S_IDLE: begin
          cnt <= 16'd0;
          if (rx_prev && !rx_sync) state <= S_START;
        end
        // middle of start bit, reject glitches
        S_START: if (cnt == half_end) begin
          cnt <= 16'd0;
          bitn <= 3'd0;
          state <= rx_sync ? S_IDLE : S_DATA;
        end
        S_DATA: if (cnt == bit_end) begin
          cnt <= 16'd0;
          bitn <= bitn + 3'd1;
          if (bitn == 3'd7) state <= S_STOP;
        end
        S_STOP: if (cnt == bit_end) begin
          state <= S_IDLE;
          valid_q <= rx_sync;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_DATA && cnt == bit_end) begin
      shreg <= {rx_sync, shreg[7:1]};
    end
  end

  assign byte_valid_o = valid_q;
  assign byte_o = shreg;

endmodule

// File: uart_port.sv
`timescale 1ns/1ps

module uart_port (
  input  logic        clk,
  input  logic        resetn,
  bus_if.target       bus,
  input  logic [15:0] div_i,
  output logic        tx_o,
  input  logic        rx_i
);

  logic wr, is_data, is_lsr, tx_start, tx_busy, rx_pop;
  logic byte_valid, rx_full;
  logic [7:0] rx_byte_in, rx_byte;
  logic [31:0] lsr;

  assign wr = |bus.wstrb;
  assign is_data = bus.addr[7:0] == soc_pkg::UART_DATA_OFS;
  assign is_lsr = bus.addr[7:0] == soc_pkg::UART_LSR_OFS;

  // writes while busy are acked and lost
  assign tx_start = bus.valid && wr && is_data;
  assign rx_pop = bus.valid && !wr && is_data;

  uart_tx u_tx (
    .clk    (clk),
    .resetn (resetn),
    .start_i(tx_start),
    .data_i (bus.wdata[7:0]),
    .div_i  (div_i),
    .busy_o (tx_busy),
    .tx_o   (tx_o)
  );

  uart_rx u_rx (
    .clk         (clk),
    .resetn      (resetn),
    .rx_i        (rx_i),
    .div_i       (div_i),
    .byte_valid_o(byte_valid),
    .byte_o      (rx_byte_in)
  );

  ////////////////////////////////////////
  // receive holding register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      rx_full <= 1'b0;
    end else begin
      if (rx_pop) begin
        rx_full <= 1'b0;
      end
      // new byte dropped when full
      if (byte_valid && !rx_full) begin
        rx_full <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_valid && !rx_full) begin
      rx_byte <= rx_byte_in;
    end
  end

  ////////////////////////////////////////
  // register reads
  ////////////////////////////////////////

  always_comb begin
    lsr = 32'h0;
    lsr[soc_pkg::LSR_DR_BIT] = rx_full;
    lsr[soc_pkg::LSR_THRE_BIT] = !tx_busy;
    lsr[soc_pkg::LSR_TEMT_BIT] = !tx_busy;
  end

  always_ff @(posedge clk) begin
    if (bus.valid) begin
      if (is_data) begin
        bus.rdata <= rx_full ? {24'h0, rx_byte} : soc_pkg::RX_EMPTY;
      end else if (is_lsr) begin
        bus.rdata <= lsr;
      end else begin
        bus.rdata <= 32'h0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.valid;
    end
  end

  a_ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
    bus.ready |=> !bus.ready);

endmodule

// File: boot_ram.sv
`timescale 1ns/1ps

module boot_ram (
  input  logic  clk,
  input  logic  resetn,
  bus_if.target bus
);

  logic [31:0] mem [soc_pkg::RAM_WORDS];
  logic [soc_pkg::RAM_AW-1:0] widx;

  // byte address to word index
  assign widx = bus.addr[soc_pkg::RAM_AW+1:2];

  always_ff @(posedge clk) begin
    if (bus.valid) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.wstrb[b]) begin
          mem[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
      bus.rdata <= mem[widx];
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.valid;
    end
  end

endmodule

// File: sys_regs.sv
`timescale 1ns/1ps

module sys_regs (
  input  logic        clk,
  input  logic        resetn,
  bus_if.target       bus,
  output logic [15:0] uart_div_o
);

  logic [31:0] div_q;
  logic [7:0] ofs;
  logic wr;

  assign ofs = bus.addr[7:0];
  assign wr = |bus.wstrb;

  // divider, the only writable register here
  always_ff @(posedge clk) begin
    if (!resetn) begin
      div_q <= soc_pkg::DIV_RESET;
    end else if (bus.valid && wr && ofs == soc_pkg::DIV_OFS) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.wstrb[b]) begin
          div_q[8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.valid) begin
      case (ofs)
        soc_pkg::FREQ_OFS:    bus.rdata <= soc_pkg::SYSTEM_CLK;
        soc_pkg::MEMSIZE_OFS: bus.rdata <= soc_pkg::RAM_BYTES;
        soc_pkg::DIV_OFS:     bus.rdata <= div_q;
        default:              bus.rdata <= 32'h0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.valid;
    end
  end

  // uart bit period
  assign uart_div_o = div_q[15:0];

endmodule

// File: bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric (
  input  logic         clk,
  input  logic         resetn,
  input  logic         mem_valid_i,
  input  logic         mem_instr_i,
  input  logic [31:0]  mem_addr_i,
  input  logic [31:0]  mem_wdata_i,
  input  logic [3:0]   mem_wstrb_i,
  output logic         mem_ready_o,
  output logic [31:0]  mem_rdata_o,
  output logic         mem_fault_o,
  bus_if.fabric        ram_bus,
  bus_if.fabric        sys_bus,
  bus_if.fabric        uart_bus [soc_pkg::NUM_UARTS]
);

  logic is_ram, is_io, sys_hit, acc_fault, req;
  logic fault_valid, fault_q, unmatched_valid, unmatched_q;
  logic [soc_pkg::NUM_UARTS-1:0] uart_hit, uart_ready;
  logic [31:0] uart_rdata [soc_pkg::NUM_UARTS];

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  assign is_ram = mem_addr_i < soc_pkg::RAM_BYTES;
  assign is_io = (mem_addr_i >= soc_pkg::IO_START) && (mem_addr_i <= soc_pkg::IO_END);
  assign sys_hit = (mem_addr_i & ~(soc_pkg::SYS_SPAN - 32'd1)) == soc_pkg::SYS_BASE;

  // fetches only from ram, data from ram or the io window
  assign acc_fault = mem_instr_i ? !is_ram : !(is_ram || is_io);
  assign req = mem_valid_i && !acc_fault;

  assign ram_bus.valid = req && is_ram && !ram_bus.ready;
  assign ram_bus.addr = mem_addr_i;
  assign ram_bus.wdata = mem_wdata_i;
  assign ram_bus.wstrb = mem_wstrb_i;

  assign sys_bus.valid = req && is_io && sys_hit && !sys_bus.ready;
  assign sys_bus.addr = mem_addr_i;
  assign sys_bus.wdata = mem_wdata_i;
  assign sys_bus.wstrb = mem_wstrb_i;

  for (genvar g = 0; g < soc_pkg::NUM_UARTS; g++) begin : g_uart
    localparam logic [31:0] PORT_BASE = soc_pkg::UART_BASE + soc_pkg::UART_STRIDE * g;

    assign uart_hit[g] = (mem_addr_i & ~(soc_pkg::UART_STRIDE - 32'd1)) == PORT_BASE;
    assign uart_bus[g].valid = req && is_io && uart_hit[g] && !uart_bus[g].ready;
    assign uart_bus[g].addr = mem_addr_i;
    assign uart_bus[g].wdata = mem_wdata_i;
    assign uart_bus[g].wstrb = mem_wstrb_i;
    assign uart_ready[g] = uart_bus[g].ready;
    assign uart_rdata[g] = uart_bus[g].rdata;
  end

  ////////////////////////////////////////
  // replies from the fabric itself
  ////////////////////////////////////////

  assign fault_valid = mem_valid_i && acc_fault && !fault_q;
  assign unmatched_valid = req && is_io && !sys_hit && !(|uart_hit) && !unmatched_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      fault_q <= 1'b0;
      unmatched_q <= 1'b0;
    end else begin
      fault_q <= fault_valid;
      unmatched_q <= unmatched_valid;
    end
  end

  // response mux, fault and unmatched read zero
  assign mem_ready_o = ram_bus.ready || sys_bus.ready || (|uart_ready) || fault_q || unmatched_q;
  assign mem_fault_o = fault_q;

  always_comb begin
    mem_rdata_o = 32'h0;
    if (ram_bus.ready) begin
      mem_rdata_o = ram_bus.rdata;
    end else if (sys_bus.ready) begin
      mem_rdata_o = sys_bus.rdata;
    end
    for (int n = 0; n < soc_pkg::NUM_UARTS; n++) begin
      if (uart_ready[n]) begin
        mem_rdata_o = uart_rdata[n];
      end
    end
  end

  a_one_source: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0({ram_bus.ready, sys_bus.ready, uart_ready, fault_q, unmatched_q}));

endmodule

// File: soc_top.sv
`timescale 1ns/1ps

module soc_top (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          mem_valid_i,
  input  logic                          mem_instr_i,
  input  logic [31:0]                   mem_addr_i,
  input  logic [31:0]                   mem_wdata_i,
  input  logic [3:0]                    mem_wstrb_i,
  input  logic [soc_pkg::NUM_UARTS-1:0] uart_rx_i,
  output logic                          mem_ready_o,
  output logic [31:0]                   mem_rdata_o,
  output logic                          mem_fault_o,
  output logic [soc_pkg::NUM_UARTS-1:0] uart_tx_o
);

  bus_if ram_bus ();
  bus_if sys_bus ();
  bus_if uart_bus [soc_pkg::NUM_UARTS] ();

  logic [15:0] uart_div;

  bus_fabric u_fabric (
    .clk        (clk),
    .resetn     (resetn),
    .mem_valid_i(mem_valid_i),
    .mem_instr_i(mem_instr_i),
    .mem_addr_i (mem_addr_i),
    .mem_wdata_i(mem_wdata_i),
    .mem_wstrb_i(mem_wstrb_i),
    .mem_ready_o(mem_ready_o),
    .mem_rdata_o(mem_rdata_o),
    .mem_fault_o(mem_fault_o),
    .ram_bus    (ram_bus),
    .sys_bus    (sys_bus),
    .uart_bus   (uart_bus)
  );

  boot_ram u_ram (
    .clk   (clk),
    .resetn(resetn),
    .bus   (ram_bus)
  );

  sys_regs u_sys (
    .clk       (clk),
    .resetn    (resetn),
    .bus       (sys_bus),
    .uart_div_o(uart_div)
  );

  // all ports share one bit period
  for (genvar g = 0; g < soc_pkg::NUM_UARTS; g++) begin : g_uart
    uart_port u_uart (
      .clk   (clk),
      .resetn(resetn),
      .bus   (uart_bus[g]),
      .div_i (uart_div),
      .tx_o  (uart_tx_o[g]),
      .rx_i  (uart_rx_i[g])
    );
  end

endmodule

// File: tb_soc.sv
`timescale 1ns/1ps

module tb_soc;

  localparam int RESET_CYCLES = 4;
  localparam int MAX_WAIT = 8;
  localparam int MAX_POLLS = 200;
  localparam int BYTES_PER_PORT = 20;
  // one access takes three clocks including the idle cycle
  localparam int ACC_CYCLES = 3;
  localparam int RAM_BUDGET = (soc_pkg::RAM_WORDS + 2 * 200) * ACC_CYCLES;
  localparam int SYS_BUDGET = 12 * ACC_CYCLES;
  localparam int UART_BUDGET = 40 * 12 * int'(soc_pkg::DIV_RESET[15:0]) + 40 * 8 * ACC_CYCLES;
  localparam int FAULT_BUDGET = 56 * ACC_CYCLES;
  localparam int UNMATCHED_BUDGET = 20 * ACC_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + RAM_BUDGET + SYS_BUDGET + UART_BUDGET
                                       + FAULT_BUDGET + UNMATCHED_BUDGET);

  logic clk = 1'b0;
  logic resetn;
  logic mem_valid_i, mem_instr_i, mem_ready_o, mem_fault_o;
  logic [31:0] mem_addr_i, mem_wdata_i, mem_rdata_o;
  logic [3:0] mem_wstrb_i;
  logic [soc_pkg::NUM_UARTS-1:0] uart_tx, uart_rx;

  logic [31:0] lfsr_state = 32'h51d1_e285;
  logic [31:0] model_ram [soc_pkg::RAM_WORDS];
  logic [31:0] model_div;
  int err_cnt = 0;
  int lat_errs = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;

  always #10 clk = ~clk;

  // serial loopback on every port
  assign uart_rx = uart_tx;

  soc_top DUT (
    .clk        (clk),
    .resetn     (resetn),
    .mem_valid_i(mem_valid_i),
    .mem_instr_i(mem_instr_i),
    .mem_addr_i (mem_addr_i),
    .mem_wdata_i(mem_wdata_i),
    .mem_wstrb_i(mem_wstrb_i),
    .uart_rx_i  (uart_rx),
    .mem_ready_o(mem_ready_o),
    .mem_rdata_o(mem_rdata_o),
    .mem_fault_o(mem_fault_o),
    .uart_tx_o  (uart_tx)
  );

  ////////////////////////////////////////
  // random numbers and model rules
  ////////////////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = 32'h0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9E37_79B9) ^ 32'h5A5A_5A5A;
  endfunction

  function automatic logic hits_register_block(input logic [31:0] a);
    logic uart_blk;
    logic sys_blk;
    uart_blk = (a >= soc_pkg::UART_BASE)
            && (a < soc_pkg::UART_BASE + soc_pkg::UART_STRIDE * soc_pkg::NUM_UARTS);
    sys_blk = (a >= soc_pkg::SYS_BASE) && (a < soc_pkg::SYS_BASE + soc_pkg::SYS_SPAN);
    return uart_blk || sys_blk;
  endfunction

  function automatic logic [31:0] sys_addr(input logic [7:0] ofs);
    return soc_pkg::SYS_BASE + {24'h0, ofs};
  endfunction

  function automatic logic [31:0] uart_addr(input int p, input logic [7:0] ofs);
    return soc_pkg::UART_BASE + soc_pkg::UART_STRIDE * 32'(p) + {24'h0, ofs};
  endfunction

  ////////////////////////////////////////
  // checks and bus access
  ////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_result(input string name, input int errors);
    if (errors == 0) begin
      $display("test %s: ok", name);
      pass_cnt++;
    end else begin
      $display("test %s: failed with %0d errors", name, errors);
      fail_cnt++;
    end
  endtask

  task automatic bus_access(input string name, input logic instr, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            output logic [31:0] rdata, output logic fault);
    int lat;
    int errs;
    errs = err_cnt;
    @(posedge clk);
    mem_valid_i <= 1'b1;
    mem_instr_i <= instr;
    mem_addr_i <= addr;
    mem_wdata_i <= wdata;
    mem_wstrb_i <= wstrb;
    lat = 0;
    // sample mid-cycle, away from the clock edge
    @(negedge clk);
    while (!mem_ready_o && lat < MAX_WAIT) begin
      @(negedge clk);
      lat++;
    end
    if (!mem_ready_o) begin
      $display("%s: bus gave no ready within %0d cycles", name, MAX_WAIT);
      err_cnt++;
    end
    check({name, " latency"}, 32'd1, lat);
    rdata = mem_rdata_o;
    fault = mem_fault_o;
    @(posedge clk);
    mem_valid_i <= 1'b0;
    mem_instr_i <= 1'b0;
    mem_wstrb_i <= 4'h0;
    @(negedge clk);
    check({name, " ready pulse"}, 32'd0, {31'b0, mem_ready_o});
    lat_errs += err_cnt - errs;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic ram_random_access();
    logic [31:0] r, wd, rd;
    logic [soc_pkg::RAM_AW-1:0] widx;
    logic [3:0] strb;
    logic flt;
    int errs;
    errs = err_cnt;
    for (int i = 0; i < soc_pkg::RAM_WORDS; i++) begin
      widx = i[soc_pkg::RAM_AW-1:0];
      model_ram[widx] = fill_word(32'(widx) << 2);
      bus_access("ram fill", 1'b0, 32'(widx) << 2, model_ram[widx], 4'hF, rd, flt);
    end
    for (int n = 0; n < 200; n++) begin
      r = take_bits(soc_pkg::RAM_AW);
      widx = r[soc_pkg::RAM_AW-1:0];
      wd = take_bits(32);
      r = take_bits(4);
      strb = (r[3:0] == 4'h0) ? 4'hF : r[3:0];
      bus_access("ram write", 1'b0, 32'(widx) << 2, wd, strb, rd, flt);
      check("ram write fault", 32'd0, {31'b0, flt});
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          model_ram[widx][8*b +: 8] = wd[8*b +: 8];
        end
      end
      r = take_bits(1);
      if (r[0]) begin
        r = take_bits(soc_pkg::RAM_AW);
        widx = r[soc_pkg::RAM_AW-1:0];
        bus_access("ram read", 1'b0, 32'(widx) << 2, 32'h0, 4'h0, rd, flt);
        check("ram read", model_ram[widx], rd);
        check("ram read fault", 32'd0, {31'b0, flt});
      end
    end
    report_result("ram", err_cnt - errs);
  endtask

  task automatic sys_register_rw();
    logic [31:0] r, lo, rd;
    logic flt;
    int errs;
    errs = err_cnt;
    bus_access("freq read", 1'b0, sys_addr(soc_pkg::FREQ_OFS), 32'h0, 4'h0, rd, flt);
    check("freq read", soc_pkg::SYSTEM_CLK, rd);
    bus_access("freq write", 1'b0, sys_addr(soc_pkg::FREQ_OFS), take_bits(32), 4'hF, rd, flt);
    bus_access("freq reread", 1'b0, sys_addr(soc_pkg::FREQ_OFS), 32'h0, 4'h0, rd, flt);
    check("freq after write", soc_pkg::SYSTEM_CLK, rd);
    bus_access("memsize read", 1'b0, sys_addr(soc_pkg::MEMSIZE_OFS), 32'h0, 4'h0, rd, flt);
    check("memsize read", soc_pkg::RAM_BYTES, rd);
    bus_access("memsize write", 1'b0, sys_addr(soc_pkg::MEMSIZE_OFS), take_bits(32), 4'hF,
               rd, flt);
    bus_access("memsize reread", 1'b0, sys_addr(soc_pkg::MEMSIZE_OFS), 32'h0, 4'h0, rd, flt);
    check("memsize after write", soc_pkg::RAM_BYTES, rd);
    // unused offset in the block
    bus_access("sys other read", 1'b0, sys_addr(8'h08), 32'h0, 4'h0, rd, flt);
    check("sys other read", 32'h0, rd);
    // bit period kept between 6 and 12 clocks
    r = take_bits(16);
    lo = take_bits(8) % 32'd7;
    model_div = {r[15:0], 16'd6 + lo[15:0]};
    bus_access("div write", 1'b0, sys_addr(soc_pkg::DIV_OFS), model_div, 4'hF, rd, flt);
    bus_access("div read", 1'b0, sys_addr(soc_pkg::DIV_OFS), 32'h0, 4'h0, rd, flt);
    check("div readback", model_div, rd);
    model_div = soc_pkg::DIV_RESET;
    bus_access("div restore", 1'b0, sys_addr(soc_pkg::DIV_OFS), model_div, 4'hF, rd, flt);
    bus_access("div read", 1'b0, sys_addr(soc_pkg::DIV_OFS), 32'h0, 4'h0, rd, flt);
    check("div restored", model_div, rd);
    report_result("sys_regs", err_cnt - errs);
  endtask

  task automatic uart_loopback();
    logic [31:0] r, rd, lsr_idle;
    logic [7:0] bval;
    logic flt;
    int polls;
    int errs;
    errs = err_cnt;
    lsr_idle = 32'h0;
    lsr_idle[soc_pkg::LSR_THRE_BIT] = 1'b1;
    lsr_idle[soc_pkg::LSR_TEMT_BIT] = 1'b1;
    // serial lines idle high before any traffic
    check("uart tx idle", 32'((1 << soc_pkg::NUM_UARTS) - 1), 32'(uart_tx));
    for (int p = 0; p < soc_pkg::NUM_UARTS; p++) begin
      for (int n = 0; n < BYTES_PER_PORT; n++) begin
        r = take_bits(8);
        bval = r[7:0];
        polls = 0;
        do begin
          bus_access("lsr poll", 1'b0, uart_addr(p, soc_pkg::UART_LSR_OFS), 32'h0, 4'h0,
                     rd, flt);
          polls++;
        end while (!rd[soc_pkg::LSR_THRE_BIT] && polls < MAX_POLLS);
        if (!rd[soc_pkg::LSR_THRE_BIT]) begin
          $display("uart %0d: transmitter stayed busy for %0d polls", p, MAX_POLLS);
          err_cnt++;
        end
        check($sformatf("uart%0d lsr idle %0d", p, n), lsr_idle, rd);
        bus_access("uart write", 1'b0, uart_addr(p, soc_pkg::UART_DATA_OFS), {24'h0, bval},
                   4'h1, rd, flt);
        polls = 0;
        do begin
          bus_access("lsr poll", 1'b0, uart_addr(p, soc_pkg::UART_LSR_OFS), 32'h0, 4'h0,
                     rd, flt);
          polls++;
        end while (!rd[soc_pkg::LSR_DR_BIT] && polls < MAX_POLLS);
        if (!rd[soc_pkg::LSR_DR_BIT]) begin
          $display("uart %0d: looped back byte never arrived", p);
          err_cnt++;
        end
        bus_access("uart read", 1'b0, uart_addr(p, soc_pkg::UART_DATA_OFS), 32'h0, 4'h0,
                   rd, flt);
        check($sformatf("uart%0d byte %0d", p, n), {24'h0, bval}, rd);
        bus_access("uart reread", 1'b0, uart_addr(p, soc_pkg::UART_DATA_OFS), 32'h0, 4'h0,
                   rd, flt);
        check($sformatf("uart%0d empty %0d", p, n), soc_pkg::RX_EMPTY, rd);
      end
    end
    report_result("uart", err_cnt - errs);
  endtask

  task automatic fault_replies();
    logic [31:0] r, addr, rd;
    logic [soc_pkg::RAM_AW-1:0] widx;
    logic flt;
    int errs;
    errs = err_cnt;
    for (int n = 0; n < 16; n++) begin
      addr = soc_pkg::IO_START + take_bits(25);
      bus_access("io fetch", 1'b1, addr, 32'h0, 4'h0, rd, flt);
      check("io fetch fault", 32'd1, {31'b0, flt});
      check("io fetch rdata", 32'h0, rd);
    end
    for (int n = 0; n < 16; n++) begin
      addr = soc_pkg::RAM_BYTES + take_bits(31);
      bus_access("high fetch", 1'b1, addr, 32'h0, 4'h0, rd, flt);
      check("high fetch fault", 32'd1, {31'b0, flt});
      check("high fetch rdata", 32'h0, rd);
    end
    // below the io window or above it
    for (int n = 0; n < 16; n++) begin
      r = take_bits(1);
      if (r[0]) begin
        addr = soc_pkg::RAM_BYTES + take_bits(27);
      end else begin
        addr = soc_pkg::IO_END + 32'd1 + take_bits(31);
      end
      r = take_bits(4);
      bus_access("data outside", 1'b0, addr, take_bits(32), r[3:0], rd, flt);
      check("data outside fault", 32'd1, {31'b0, flt});
      check("data outside rdata", 32'h0, rd);
    end
    for (int n = 0; n < 8; n++) begin
      r = take_bits(soc_pkg::RAM_AW);
      widx = r[soc_pkg::RAM_AW-1:0];
      addr = 32'(widx) << 2;
      bus_access("ram fetch", 1'b1, addr, 32'h0, 4'h0, rd, flt);
      check("ram fetch fault", 32'd0, {31'b0, flt});
      check("ram fetch rdata", model_ram[widx], rd);
    end
    report_result("faults", err_cnt - errs);
  endtask

  task automatic unmatched_io_reads();
    logic [31:0] addr, rd;
    logic flt;
    int errs;
    errs = err_cnt;
    for (int n = 0; n < 20; n++) begin
      do begin
        addr = soc_pkg::IO_START + take_bits(25);
      end while (hits_register_block(addr));
      bus_access("unmatched io", 1'b0, addr, 32'h0, 4'h0, rd, flt);
      check("unmatched rdata", 32'h0, rd);
      check("unmatched fault", 32'd0, {31'b0, flt});
    end
    report_result("unmatched_io", err_cnt - errs);
  endtask

  ////////////////////////////////////////
  // run and watchdog
  ////////////////////////////////////////

  initial begin
    resetn = 1'b0;
    mem_valid_i = 1'b0;
    mem_instr_i = 1'b0;
    mem_addr_i = 32'h0;
    mem_wdata_i = 32'h0;
    mem_wstrb_i = 4'h0;
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
    ram_random_access();
    sys_register_rw();
    uart_loopback();
    fault_replies();
    unmatched_io_reads();
    report_result("latency", lat_errs);
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: all.f
soc_pkg.sv
bus_if.sv
uart_tx.sv
uart_rx.sv
uart_port.sv
boot_ram.sv
sys_regs.sv
bus_fabric.sv
soc_top.sv
tb_soc.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_soc --Mdir obj_dir -o tb_soc
./obj_dir/tb_soc > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
